//--- tb.f
+incdir+.
bus_pkg.sv
serial_pkg.sv
uart_rx.sv
rom_loader.sv
dp_ram.sv
mem_map.sv
kbd_port.sv
soc_top.sv
tb_soc_asserts.sv
tb_soc.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the SoC testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_soc -f tb.f -o tb_soc_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_soc_sim > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

# Result comes from the log only
if grep -qx ">>> PASS" "$log"; then
    echo "result: pass"
    exit 0
fi
echo "result: fail"
exit 1

//--- tb_soc.sv
`default_nettype none
`include "soc_config.svh"

module tb_soc import bus_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int RAM_WRITES      = 48;
    localparam int VRAM_WRITES     = 16;
    localparam int BYTE_CYCLES     = 10 * `CLKS_PER_BIT;   // Start bit, 8 data bits and stop bit
    localparam int WATCHDOG_CYCLES = `BOOT_ROM_BYTES * BYTE_CYCLES + 4000;

    logic        clk = 1'b0;
    logic        arst_n;
    mem_req_t    mem_req;
    logic [7:0]  rdata;
    port_req_t   port_req;
    logic [7:0]  port_rdata;
    logic        rxd;
    logic        cpu_hold;
    logic [7:0]  kbd_code;
    logic        kbd_valid;
    logic [10:0] vid_addr;
    logic [7:0]  vid_rdata;

    logic [15:0] lfsr;                // Stimulus generator state
    int          mismatch_cnt;
    int          fail_cnt;            // Timeouts and other failures

    // Reference memories
    logic [7:0]  ram_model  [`MAIN_RAM_BYTES];
    logic [7:0]  vram_model [`VIDEO_RAM_BYTES];
    logic [7:0]  rom_model  [`BOOT_ROM_BYTES];

    soc_top i_soc_top (
        .clk        (clk),
        .arst_n     (arst_n),
        .mem_req    (mem_req),
        .rdata      (rdata),
        .port_req   (port_req),
        .port_rdata (port_rdata),
        .rxd        (rxd),
        .cpu_hold   (cpu_hold),
        .kbd_code   (kbd_code),
        .kbd_valid  (kbd_valid),
        .vid_addr   (vid_addr),
        .vid_rdata  (vid_rdata)
    );

    always #10 clk = ~clk;            // 20 ns period

    // --------------------
    // Helpers
    // --------------------

    // Fibonacci LFSR on taps 16 14 13 11 stepped once per bit
    function automatic logic [15:0] lfsr_bits(input int n);
        logic [15:0] v;
        logic        fb;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v    = {v[14:0], fb};
        end
        return v;
    endfunction

    function automatic logic [7:0] random_byte();
        logic [15:0] v;
        v = lfsr_bits(8);
        return v[7:0];
    endfunction

    // Inputs change 2 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic report_mismatch(input string what, input logic [7:0] got,
                                   input logic [7:0] exp);
        mismatch_cnt++;
        $display("mismatch at %0d ns: %s, got %02h, expected %02h", $time, what, got, exp);
    endtask

    task automatic apply_reset();
        arst_n = 1'b0;
        repeat (10) @(posedge clk);
        #2;
        arst_n = 1'b1;
        next_cycle();
    endtask

    task automatic mem_write(input logic [15:0] a, input logic [7:0] d);
        mem_req = '{addr: a, wdata: d, we: 1'b1};
        next_cycle();
        mem_req.we = 1'b0;
    endtask

    // Data registered from the address of the cycle before
    task automatic mem_read(input logic [15:0] a, output logic [7:0] d);
        mem_req = '{addr: a, wdata: 8'h00, we: 1'b0};
        next_cycle();
        d = rdata;
    endtask

    task automatic port_read(input logic [15:0] a, output logic [7:0] d);
        port_req = '{addr: a, rd: 1'b1};
        next_cycle();
        port_req.rd = 1'b0;           // Single-cycle strobe
        d = port_rdata;
    endtask

    task automatic kbd_strobe(input logic [7:0] code);
        kbd_code  = code;
        kbd_valid = 1'b1;
        next_cycle();
        kbd_valid = 1'b0;
    endtask

    // 8N1 frame sent LSB first
    task automatic uart_send_byte(input logic [7:0] b);
        logic [9:0] frame;
        int         i;
        frame = {1'b1, b, 1'b0};
        for (i = 0; i < 10; i++) begin
            rxd = frame[i];
            repeat (`CLKS_PER_BIT) next_cycle();
        end
    endtask

    // --------------------
    // Tests
    // --------------------
    task automatic ram_readback();
        logic [15:0] addr_q [$];
        logic [15:0] a;
        logic [7:0]  d;
        logic [7:0]  got;
        int          i;
        for (i = 0; i < RAM_WRITES; i++) begin
            a = lfsr_bits(14);        // Upper bits zero so inside RAM
            d = random_byte();
            mem_write(a, d);
            ram_model[a[13:0]] = d;
            addr_q.push_back(a);
        end
        for (i = 0; i < addr_q.size(); i++) begin
            a = addr_q[i];
            mem_read(a, got);
            if (got !== ram_model[a[13:0]]) report_mismatch("RAM read-back", got,
                                                            ram_model[a[13:0]]);
        end
    endtask

    task automatic vram_mirror();
        logic [10:0] n_q [$];
        logic [15:0] r;
        logic [15:0] a;
        logic [10:0] n;
        logic [7:0]  d;
        logic [7:0]  got;
        int          i;
        for (i = 0; i < VRAM_WRITES; i++) begin
            r = lfsr_bits(11);
            n = r[10:0];
            d = random_byte();
            mem_write(`VRAM_BASE | {5'b0, n}, d);
            vram_model[n] = d;
            n_q.push_back(n);
        end
        for (i = 0; i < n_q.size(); i++) begin
            n = n_q[i];
            a = (`VRAM_BASE | {5'b0, n}) + 16'(`VIDEO_RAM_BYTES);   // Upper mirror
            mem_read(a, got);
            if (got !== vram_model[n]) report_mismatch("VRAM mirror read", got, vram_model[n]);
            vid_addr = n;
            next_cycle();
            if (vid_rdata !== vram_model[n]) report_mismatch("display port", vid_rdata,
                                                             vram_model[n]);
        end
    endtask

    task automatic keyboard_port();
        logic [7:0] got;
        logic [7:0] c1;
        logic [7:0] c2;
        port_read(`PORT_KBD_STATUS, got);
        if (got !== 8'h00) report_mismatch("status after reset", got, 8'h00);
        c1 = random_byte();
        kbd_strobe(c1);
        port_read(`PORT_KBD_STATUS, got);
        if (got !== 8'h01) report_mismatch("status after one code", got, 8'h01);
        port_read(`PORT_KBD_DATA, got);
        if (got !== c1) report_mismatch("data after one code", got, c1);
        port_read(`PORT_KBD_STATUS, got);
        if (got !== 8'h00) report_mismatch("status after data read", got, 8'h00);
        // Second code lands before any read
        c1 = random_byte();
        c2 = random_byte();
        kbd_strobe(c1);
        kbd_strobe(c2);
        port_read(`PORT_KBD_STATUS, got);
        if (got !== 8'h03) report_mismatch("status on overrun", got, 8'h03);
        port_read(`PORT_KBD_DATA, got);
        if (got !== c2) report_mismatch("data on overrun", got, c2);
        port_read(`PORT_KBD_STATUS, got);
        if (got !== 8'h00) report_mismatch("status after overrun read", got, 8'h00);
        port_read(16'h0061, got);
        if (got !== 8'h00) report_mismatch("unmapped port 0x61", got, 8'h00);
    endtask

    task automatic serial_boot();
        logic [7:0] got;
        int         k;
        int         wait_cnt;
        if (cpu_hold !== 1'b0) report_mismatch("cpu_hold before load", {7'b0, cpu_hold}, 8'h00);
        for (k = 0; k < `BOOT_ROM_BYTES; k++) rom_model[8'(k)] = random_byte();
        for (k = 0; k < `BOOT_ROM_BYTES; k++) begin
            uart_send_byte(rom_model[8'(k)]);
            if (cpu_hold !== 1'b1) report_mismatch("cpu_hold during load", {7'b0, cpu_hold},
                                                   8'h01);
        end
        wait_cnt = 0;
        while (cpu_hold === 1'b1 && wait_cnt < 4 * `CLKS_PER_BIT) begin
            next_cycle();
            wait_cnt++;
        end
        if (cpu_hold !== 1'b0) begin
            fail_cnt++;
            $display("cpu_hold did not fall after the last boot byte");
        end
        for (k = 0; k < `BOOT_ROM_BYTES; k++) begin
            mem_read(`ROM_BASE + 16'(k), got);
            if (got !== rom_model[8'(k)]) report_mismatch("ROM read", got, rom_model[8'(k)]);
            mem_read(16'hF000 + 16'(k), got);   // Mirror in the upper half
            if (got !== rom_model[8'(k)]) report_mismatch("ROM mirror read", got,
                                                          rom_model[8'(k)]);
        end
    endtask

    task automatic rom_protection();
        logic [7:0] got;
        mem_write(`ROM_BASE, ~rom_model[0]);    // CPU write must be dropped
        mem_read(`ROM_BASE, got);
        if (got !== rom_model[0]) report_mismatch("ROM after CPU write", got, rom_model[0]);
        mem_write(16'h4000, 8'hA5);
        mem_read(16'h4000, got);
        if (got !== 8'h00) report_mismatch("unmapped 0x4000", got, 8'h00);
        mem_read(16'hC000, got);
        if (got !== 8'h00) report_mismatch("unmapped 0xC000", got, 8'h00);
    endtask

    // --------------------
    // Sequence and watchdog
    // --------------------
    initial begin
        arst_n       = 1'b0;
        mem_req      = '0;
        port_req     = '0;
        rxd          = 1'b1;          // Line idle
        kbd_code     = 8'h00;
        kbd_valid    = 1'b0;
        vid_addr     = '0;
        lfsr         = 16'd33;
        mismatch_cnt = 0;
        fail_cnt     = 0;
        apply_reset();
        keyboard_port();              // Status must still be clean
        ram_readback();
        vram_mirror();
        serial_boot();
        rom_protection();
        next_cycle();
        $display("errors: %0d mismatch, %0d other, %0d assertion",
                 mismatch_cnt, fail_cnt, i_soc_top.i_asserts.assert_fails);
        if (mismatch_cnt + fail_cnt + i_soc_top.i_asserts.assert_fails == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb_soc_asserts.sv
`default_nettype none
`include "soc_config.svh"

module tb_soc_asserts import bus_pkg::*, serial_pkg::*; (
    input logic       clk,
    input logic       arst_n,
    input logic       cpu_hold,
    input rom_wr_t    rom_wr,         // Loader write into the boot ROM
    input port_req_t  port_req,
    input logic [7:0] port_rdata
);

    timeunit 1ns;
    timeprecision 100ps;

    int   assert_fails = 0;           // Failed assertion count
    logic port_unmapped;

    // Read strobe on a port the keyboard block does not decode
    assign port_unmapped = port_req.rd
                           && port_req.addr != `PORT_KBD_DATA
                           && port_req.addr != `PORT_KBD_STATUS;

    // --------------------
    // Loader and ports
    // --------------------
    hold_after_reset: assert property (@(posedge clk) $rose(arst_n) |-> !cpu_hold)
        else begin
            $error("cpu_hold high in the cycle after reset");
            assert_fails++;
        end

    rom_write_in_session: assert property (
        @(posedge clk) disable iff (!arst_n) rom_wr.we |-> cpu_hold)
        else begin
            $error("ROM write while the loader is idle");
            assert_fails++;
        end

    unmapped_port_zero: assert property (
        @(posedge clk) disable iff (!arst_n) port_unmapped |=> port_rdata == 8'h00)
        else begin
            $error("unmapped port read returned nonzero data");
            assert_fails++;
        end

endmodule

bind soc_top tb_soc_asserts i_asserts (
    .clk        (clk),
    .arst_n     (arst_n),
    .cpu_hold   (cpu_hold),
    .rom_wr     (rom_wr),
    .port_req   (port_req),
    .port_rdata (port_rdata)
);

`default_nettype wire

//--- soc_top.sv
`default_nettype none

module soc_top import bus_pkg::*, serial_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    // CPU memory bus
    input  mem_req_t    mem_req,
    output logic [7:0]  rdata,
    // CPU port bus
    input  port_req_t   port_req,
    output logic [7:0]  port_rdata,
    // Serial boot line
    input  logic        rxd,
    output logic        cpu_hold,
    // Keyboard scan codes
    input  logic [7:0]  kbd_code,
    input  logic        kbd_valid,
    // Display scanner
    input  logic [10:0] vid_addr,
    output logic [7:0]  vid_rdata
);

    rx_byte_t rx;                     // Receiver to loader
    rom_wr_t  rom_wr;                 // Loader to boot ROM

    // --------------------
    // Serial boot path
    // --------------------
    uart_rx i_uart_rx (
        .clk    (clk),
        .arst_n (arst_n),
        .rxd    (rxd),
        .rx     (rx)
    );

    rom_loader i_rom_loader (
        .clk      (clk),
        .arst_n   (arst_n),
        .rx       (rx),
        .rom_wr   (rom_wr),
        .cpu_hold (cpu_hold)
    );

    // --------------------
    // Memory and ports
    // --------------------
    mem_map i_mem_map (
        .clk       (clk),
        .arst_n    (arst_n),
        .mem_req   (mem_req),
        .rdata     (rdata),
        .rom_wr    (rom_wr),
        .vid_addr  (vid_addr),
        .vid_rdata (vid_rdata)
    );

    kbd_port i_kbd_port (
        .clk        (clk),
        .arst_n     (arst_n),
        .port_req   (port_req),
        .port_rdata (port_rdata),
        .kbd_code   (kbd_code),
        .kbd_valid  (kbd_valid)
    );

endmodule

`default_nettype wire

//--- kbd_port.sv
`default_nettype none
`include "soc_config.svh"

module kbd_port import bus_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  port_req_t  port_req,
    output logic [7:0] port_rdata,
    input  logic [7:0] kbd_code,      // Scan code from the PS/2 block
    input  logic       kbd_valid
);

    logic [7:0] code_q;
    logic       full;                 // Unread code present
    logic       overrun;              // Code lost before a read
    logic       data_rd;
    logic       stat_rd;

    assign data_rd = port_req.rd && port_req.addr == `PORT_KBD_DATA;
    assign stat_rd = port_req.rd && port_req.addr == `PORT_KBD_STATUS;

    // --------------------
    // Status flags
    // --------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            full    <= 1'b0;
            overrun <= 1'b0;
        end else begin
            if (data_rd) begin
                full    <= 1'b0;      // Code consumed
                overrun <= 1'b0;
            end
            if (kbd_valid) begin
                full <= 1'b1;
                if (full && !data_rd) overrun <= 1'b1;   // Old code never read
            end
        end
    end

    // Latest code wins
    always_ff @(posedge clk) begin
        if (kbd_valid) code_q <= kbd_code;
    end

    // --------------------
    // Port read data
    // --------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)           port_rdata <= 8'h00;
        else if (data_rd)      port_rdata <= code_q;
        else if (stat_rd)      port_rdata <= {6'b0, overrun, full};
        else if (port_req.rd)  port_rdata <= 8'h00;   // Unmapped port
    end

endmodule

`default_nettype wire

//--- mem_map.sv
`default_nettype none
`include "soc_config.svh"

module mem_map import bus_pkg::*, serial_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  mem_req_t    mem_req,
    output logic [7:0]  rdata,
    input  rom_wr_t     rom_wr,       // Loader side of the boot ROM
    input  logic [10:0] vid_addr,     // Display scanner
    output logic [7:0]  vid_rdata
);

    localparam int ROM_AW  = $clog2(`BOOT_ROM_BYTES);
    localparam int RAM_AW  = $clog2(`MAIN_RAM_BYTES);
    localparam int VRAM_AW = $clog2(`VIDEO_RAM_BYTES);

    localparam logic [15:0] ROM_BASE  = `ROM_BASE;
    localparam logic [15:0] RAM_BASE  = `RAM_BASE;
    localparam logic [15:0] VRAM_BASE = `VRAM_BASE;

    region_e    region;
    region_e    region_q;             // Region of last cycle's address
    logic       ram_we;
    logic       vram_we;
    logic [7:0] q_rom;
    logic [7:0] q_ram;
    logic [7:0] q_vram;

    // --------------------
    // Address decode
    // --------------------
    always_comb begin
        if (mem_req.addr[15:13] == ROM_BASE[15:13])       region = ROM;    // 8K window
        else if (mem_req.addr[15:14] == RAM_BASE[15:14])  region = RAM;    // 16K
        else if (mem_req.addr[15:12] == VRAM_BASE[15:12]) region = VRAM;   // 4K window
        else                                              region = NONE;
    end

    // CPU writes only land in RAM and VRAM
    assign ram_we  = mem_req.we && region == RAM;
    assign vram_we = mem_req.we && region == VRAM;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) region_q <= NONE;
        else         region_q <= region;
    end

    // Read data follows the registered region
    always_comb begin
        case (region_q)
            ROM:     rdata = q_rom;
            RAM:     rdata = q_ram;
            VRAM:    rdata = q_vram;
            default: rdata = 8'h00;
        endcase
    end

    // --------------------
    // Memories
    // --------------------

    // Boot ROM, loader writes on A, CPU reads on B
    dp_ram #(.DEPTH(`BOOT_ROM_BYTES), .ADDR_W(ROM_AW)) i_boot_rom (
        .clk     (clk),
        .a_addr  (rom_wr.addr[ROM_AW-1:0]),
        .a_wdata (rom_wr.data),
        .a_we    (rom_wr.we),
        .a_rdata (),
        .b_addr  (mem_req.addr[ROM_AW-1:0]),   // Mirror by truncation
        .b_rdata (q_rom)
    );

    dp_ram #(.DEPTH(`MAIN_RAM_BYTES), .ADDR_W(RAM_AW)) i_main_ram (
        .clk     (clk),
        .a_addr  (mem_req.addr[RAM_AW-1:0]),
        .a_wdata (mem_req.wdata),
        .a_we    (ram_we),
        .a_rdata (q_ram),
        .b_addr  ('0),                          // Second port idle here
        .b_rdata ()
    );

    // Video RAM, port B feeds the display
    dp_ram #(.DEPTH(`VIDEO_RAM_BYTES), .ADDR_W(VRAM_AW)) i_video_ram (
        .clk     (clk),
        .a_addr  (mem_req.addr[VRAM_AW-1:0]),
        .a_wdata (mem_req.wdata),
        .a_we    (vram_we),
        .a_rdata (q_vram),
        .b_addr  (vid_addr),
        .b_rdata (vid_rdata)
    );

endmodule

`default_nettype wire

//--- dp_ram.sv
`default_nettype none

module dp_ram #(
    parameter int DEPTH  = 256,
    parameter int ADDR_W = $clog2(DEPTH)
) (
    input  logic              clk,
    // Port A, read/write
    input  logic [ADDR_W-1:0] a_addr,
    input  logic [7:0]        a_wdata,
    input  logic              a_we,
    output logic [7:0]        a_rdata,
    // Port B, read only
    input  logic [ADDR_W-1:0] b_addr,
    output logic [7:0]        b_rdata
);

    logic [7:0] mem [DEPTH];

    // --------------------
    // Port A
    // --------------------
    always_ff @(posedge clk) begin
        if (a_we) mem[a_addr] <= a_wdata;
        a_rdata <= mem[a_addr];          // Old data on same-address write
    end

    // --------------------
    // Port B
    // --------------------
    always_ff @(posedge clk) begin
        b_rdata <= mem[b_addr];          // One cycle latency, like port A
    end

endmodule

`default_nettype wire

//--- rom_loader.sv
`default_nettype none
`include "soc_config.svh"

module rom_loader import serial_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  rx_byte_t rx,
    output rom_wr_t  rom_wr,
    output logic     cpu_hold     // CPU stalled while the image loads
);

    localparam logic [7:0] LAST_ADDR = 8'(`BOOT_ROM_BYTES - 1);

    logic       active;           // Session open
    logic [7:0] byte_cnt;         // Next ROM offset
    logic [7:0] wr_addr;
    logic [7:0] wr_data;
    logic       wr_we;

    // --------------------
    // Session and counter
    // --------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            active   <= 1'b0;
            byte_cnt <= '0;
            wr_we    <= 1'b0;
        end else begin
            wr_we <= rx.valid;                       // Write one cycle after the pulse
            if (rx.valid) begin
                active   <= 1'b1;                    // First byte opens the session
                byte_cnt <= byte_cnt + 1'b1;
            end
            if (wr_we && wr_addr == LAST_ADDR) begin
                active   <= 1'b0;                    // Last write done, release CPU
                byte_cnt <= '0;
            end
        end
    end

    // Payload, captured with the strobe
    always_ff @(posedge clk) begin
        if (rx.valid) begin
            wr_addr <= byte_cnt;                     // Zero when idle
            wr_data <= rx.data;
        end
    end

    assign rom_wr   = '{addr: wr_addr, data: wr_data, we: wr_we};
    assign cpu_hold = active;

endmodule

`default_nettype wire

//--- uart_rx.sv
`default_nettype none
`include "soc_config.svh"

module uart_rx import serial_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     rxd,       // Async serial line, idle high
    output rx_byte_t rx
);

    localparam int CNT_W = $clog2(`CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] CNT_HALF = CNT_W'(`CLKS_PER_BIT / 2 - 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`CLKS_PER_BIT - 1);

    typedef enum logic [1:0] {S_IDLE, S_START, S_DATA, S_STOP} state_e;

    state_e           state;
    logic [2:0]       rxd_ff;       // [1:0] sync, [2] previous sample
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shreg;
    logic             valid_q;

    logic rxd_s;
    logic fall;

    assign rxd_s = rxd_ff[1];
    assign fall  = rxd_ff[2] & ~rxd_s;   // Start bit edge

    // --------------------
    // Line sync
    // --------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) rxd_ff <= 3'b111;   // Line idles high
        else         rxd_ff <= {rxd_ff[1:0], rxd};
    end

    // --------------------
    // Bit FSM
    // --------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= S_IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b0;             // Single-cycle strobe
            clk_cnt <= clk_cnt + 1'b1;
            case (state)
                S_IDLE: begin
                    clk_cnt <= '0;
                    if (fall) state <= S_START;
                end
                S_START: if (clk_cnt == CNT_HALF) begin
                    clk_cnt <= '0;       // Now mid-bit, rest is whole periods
                    bit_idx <= '0;
                    state   <= rxd_s ? S_IDLE : S_DATA;   // Glitch, back to idle
                end
                S_DATA: if (clk_cnt == CNT_LAST) begin
                    clk_cnt <= '0;
                    bit_idx <= bit_idx + 1'b1;
                    if (bit_idx == 3'd7) state <= S_STOP;
                end
                S_STOP: if (clk_cnt == CNT_LAST) begin
                    valid_q <= rxd_s;    // Framing error drops the byte
                    state   <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Data shift, LSB arrives first
    always_ff @(posedge clk) begin
        if (state == S_DATA && clk_cnt == CNT_LAST) shreg <= {rxd_s, shreg[7:1]};
    end

    assign rx = '{data: shreg, valid: valid_q};

endmodule

`default_nettype wire

//--- serial_pkg.sv
`default_nettype none

package serial_pkg;

    // Byte from the UART receiver, valid for one cycle
    typedef struct packed {
        logic [7:0] data;
        logic       valid;
    } rx_byte_t;

    // Loader write into the boot ROM
    typedef struct packed {
        logic [7:0] addr;   // ROM offset
        logic [7:0] data;
        logic       we;
    } rom_wr_t;

endpackage

`default_nettype wire

//--- bus_pkg.sv
`default_nettype none

package bus_pkg;

    // --------------------
    // CPU memory bus
    // --------------------

    // One request per cycle, write when we is high
    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  wdata;
        logic        we;
    } mem_req_t;

    // --------------------
    // CPU port bus
    // --------------------

    // rd is a single-cycle strobe
    typedef struct packed {
        logic [15:0] addr;
        logic        rd;
    } port_req_t;

    // Decoded memory region
    typedef enum logic [1:0] {
        ROM,    // Boot ROM, read only for the CPU
        RAM,    // Main RAM
        VRAM,   // Text video RAM
        NONE    // Unmapped, reads 0x00
    } region_e;

endpackage

`default_nettype wire

//--- soc_config.svh
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// --------------------
// Memory sizes in bytes
// --------------------
`define BOOT_ROM_BYTES   256          // Scaled down for simulation
`define MAIN_RAM_BYTES   16384
`define VIDEO_RAM_BYTES  2048         // Text screen, char and attribute

// --------------------
// Region bases, CPU address space
// --------------------
`define ROM_BASE         16'hE000     // E000-FFFF, mirrored
`define RAM_BASE         16'h0000     // 0000-3FFF
`define VRAM_BASE        16'hB000     // B000-BFFF, mirrored

// Keyboard controller ports
`define PORT_KBD_DATA    16'h0060
`define PORT_KBD_STATUS  16'h0064

// Serial line, clk cycles per bit
`define CLKS_PER_BIT     8

`endif
